/* apb4_tmr_settings.svh */
// Build settings for the APB4 timer peripheral
// Each channel owns a 16 byte window starting at TMR_CHN_SHIFT in paddr
// Register offsets are byte offsets and must stay word aligned inside that window
// The bus is fixed at 32 data bits with 4 byte strobes
`ifndef APB4_TMR_SETTINGS_SVH
`define APB4_TMR_SETTINGS_SVH

// Number of timer channels behind the single completer port
`define TMR_CHANNELS 4

// Number of paddr bits that the peripheral decodes
`define TMR_ADDR_W 12

// First paddr bit of the channel index
`define TMR_CHN_SHIFT 4

// Byte offsets of the four registers inside a channel window
`define TMR_OFS_CTRL 4'h0
`define TMR_OFS_CMP 4'h4
`define TMR_OFS_CNT 4'h8
`define TMR_OFS_STAT 4'hC

`endif

/* apb4_tmr_pkg.sv */
// Bus and channel types shared by the timer RTL
// Array sizes and the index width follow the settings header
`default_nettype none

`include "apb4_tmr_settings.svh"

package apb4_tmr_pkg;

  // Channel index as carved out of paddr, wide enough to see unmapped windows
  typedef logic [`TMR_ADDR_W-`TMR_CHN_SHIFT-1:0] chn_idx_t;

  // APB4 request as the completer sees it
  // pprot is not carried because the timer has no protection levels
  typedef struct packed {
    logic [`TMR_ADDR_W-1:0] paddr;
    logic                   pwrite;
    logic [31:0]            pwdata;
    logic [3:0]             pstrb;
    logic                   psel;
    logic                   penable;
  } apb4_req_t;

  // Request into one channel
  // stb is high only in the access cycle of a transfer addressed to that channel
  typedef struct packed {
    logic        stb;
    logic        wr;
    logic [1:0]  idx;
    logic [31:0] wdata;
    logic [3:0]  strb;
  } chn_req_t;

  // Response from one channel, data and error are combinational
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } chn_rsp_t;

  // One entry per channel, entry 0 in the low bits
  typedef chn_req_t [`TMR_CHANNELS-1:0] chn_req_arr_t;
  typedef chn_rsp_t [`TMR_CHANNELS-1:0] chn_rsp_arr_t;

endpackage

`default_nettype wire

/* apb4_tmr_decode.sv */
// Address decoder for the timer peripheral
// The channel index is captured in the setup cycle and held through access
// Byte address bits below the word are ignored, misaligned accesses hit the word
// Channel indices at or above TMR_CHANNELS are reported as unmapped
`timescale 1ns/100ps
`default_nettype none

`include "apb4_tmr_settings.svh"

module apb4_tmr_decode (
  input  logic                       apb4,
  input  logic                       arst_n,
  input  apb4_tmr_pkg::apb4_req_t    req,
  output apb4_tmr_pkg::chn_req_arr_t chn_req,
  output logic                       unmapped,
  output apb4_tmr_pkg::chn_idx_t     sel_idx
);

  import apb4_tmr_pkg::*;

  // Number of channels as an index value, for range tests
  localparam chn_idx_t NUM_CHN = $bits(chn_idx_t)'(`TMR_CHANNELS);

  logic       setup;
  logic       access;
  logic [1:0] reg_idx;

  // Setup cycle: psel without penable
  assign setup  = req.psel & ~req.penable;
  // Access cycle: both high, the completer never stretches it
  assign access = req.psel & req.penable;

  // Word index of the register inside the channel window
  assign reg_idx = 2'(req.paddr[`TMR_CHN_SHIFT-1:2]);

  // The channel index is sampled at the end of the setup cycle
  // so that the whole access cycle sees one stable selection
  always_ff @(posedge apb4 or negedge arst_n) begin
    if (!arst_n) begin
      sel_idx <= '0;
    end else if (setup) begin
      sel_idx <= req.paddr[`TMR_ADDR_W-1:`TMR_CHN_SHIFT];
    end
  end

  // Out of range channel in an access cycle
  assign unmapped = access & (sel_idx >= NUM_CHN);

  // Every channel sees the write payload
  // Only the addressed one gets the strobe
  always_comb begin
    for (int i = 0; i < `TMR_CHANNELS; i++) begin
      chn_req[i].stb   = access & (sel_idx == $bits(chn_idx_t)'(i));
      chn_req[i].wr    = req.pwrite;
      chn_req[i].idx   = reg_idx;
      chn_req[i].wdata = req.pwdata;
      chn_req[i].strb  = req.pstrb;
    end
  end

endmodule

`default_nettype wire

/* tmr_channel.sv */
// One timer channel: ctrl, cmp, a free running 32 bit counter and a match flag
// The counter wraps to zero on the edge after it equals cmp
// A write to cnt is refused with an error and leaves the counter alone
// irq is registered and trails the flag by one clock
`timescale 1ns/100ps
`default_nettype none

`include "apb4_tmr_settings.svh"

module tmr_channel (
  input  logic                   apb4,
  input  logic                   arst_n,
  input  apb4_tmr_pkg::chn_req_t req,
  output apb4_tmr_pkg::chn_rsp_t rsp,
  output logic                   irq
);

  // Register word indices inside the channel window
  localparam logic [1:0] REG_CTRL = 2'(`TMR_OFS_CTRL >> 2);
  localparam logic [1:0] REG_CMP  = 2'(`TMR_OFS_CMP >> 2);
  localparam logic [1:0] REG_CNT  = 2'(`TMR_OFS_CNT >> 2);
  localparam logic [1:0] REG_STAT = 2'(`TMR_OFS_STAT >> 2);

  logic        en_q;
  logic        ie_q;
  logic [31:0] cmp_q;
  logic [31:0] cnt_q;
  logic        flag_q;
  logic        irq_q;

  logic        wr_acc;
  logic        wr_ctrl;
  logic        wr_cmp;
  logic        wr_cnt;
  logic        clr_flag;
  logic        match;

  // Write strobes per register, only valid in the access cycle
  assign wr_acc  = req.stb & req.wr;
  assign wr_ctrl = wr_acc & (req.idx == REG_CTRL);
  assign wr_cmp  = wr_acc & (req.idx == REG_CMP);
  assign wr_cnt  = wr_acc & (req.idx == REG_CNT);

  // Write one to clear, bit 0 lives in byte lane 0
  assign clr_flag = wr_acc & (req.idx == REG_STAT) & req.strb[0] & req.wdata[0];

  // Compare hit while running
  assign match = en_q & (cnt_q == cmp_q);

  // ctrl holds enable in bit 0 and interrupt enable in bit 1
  always_ff @(posedge apb4 or negedge arst_n) begin
    if (!arst_n) begin
      en_q <= 1'b0;
      ie_q <= 1'b0;
    end else if (wr_ctrl && req.strb[0]) begin
      en_q <= req.wdata[0];
      ie_q <= req.wdata[1];
    end
  end

  // Compare value, merged bytewise under pstrb
  always_ff @(posedge apb4 or negedge arst_n) begin
    if (!arst_n) begin
      cmp_q <= '0;
    end else if (wr_cmp) begin
      for (int b = 0; b < 4; b++) begin
        if (req.strb[b]) begin
          cmp_q[8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  // Counter advances every clock while enabled and holds when disabled
  always_ff @(posedge apb4 or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
    end else if (en_q) begin
      cnt_q <= match ? '0 : cnt_q + 32'd1;
    end
  end

  // Sticky match flag
  // A clear on the same edge as a match wins
  always_ff @(posedge apb4 or negedge arst_n) begin
    if (!arst_n) begin
      flag_q <= 1'b0;
    end else if (clr_flag) begin
      flag_q <= 1'b0;
    end else if (match) begin
      flag_q <= 1'b1;
    end
  end

  // Interrupt follows flag and enable one clock later
  always_ff @(posedge apb4 or negedge arst_n) begin
    if (!arst_n) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= flag_q & ie_q;
    end
  end

  assign irq = irq_q;

  // Read data by register index, the collector gates it to the access cycle
  always_comb begin
    case (req.idx)
      REG_CTRL: rsp.rdata = {30'd0, ie_q, en_q};
      REG_CMP:  rsp.rdata = cmp_q;
      REG_CNT:  rsp.rdata = cnt_q;
      REG_STAT: rsp.rdata = {31'd0, flag_q};
      default:  rsp.rdata = '0;
    endcase
    // The counter is read only
    rsp.err = wr_cnt;
  end

endmodule

`default_nettype wire

/* apb4_tmr_rdmux.sv */
// Response collector for the timer peripheral
// pready is high in every access cycle, so there are no wait states
// Unmapped accesses read zero and return an error
`timescale 1ns/100ps
`default_nettype none

`include "apb4_tmr_settings.svh"

module apb4_tmr_rdmux (
  input  apb4_tmr_pkg::chn_rsp_arr_t chn_rsp,
  input  apb4_tmr_pkg::chn_idx_t     sel_idx,
  input  logic                       unmapped,
  input  logic                       penable,
  input  logic                       psel,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr
);

  import apb4_tmr_pkg::*;

  logic     access;
  chn_rsp_t sel_rsp;

  assign access = psel & penable;

  // Pick the addressed channel by comparison, so an index past the
  // last channel never reaches into the array
  always_comb begin
    sel_rsp = '0;
    for (int i = 0; i < `TMR_CHANNELS; i++) begin
      if (sel_idx == $bits(chn_idx_t)'(i)) begin
        sel_rsp = chn_rsp[i];
      end
    end
    // Unmapped window gives zero data with error
    if (unmapped) begin
      sel_rsp.rdata = '0;
      sel_rsp.err   = 1'b1;
    end
  end

  // Data and error only show in the access cycle and read zero otherwise
  assign prdata  = access ? sel_rsp.rdata : '0;
  assign pslverr = access & sel_rsp.err;
  assign pready  = access;

endmodule

`default_nettype wire

/* apb4_tmr_top.sv */
// APB4 timer peripheral with TMR_CHANNELS identical channels
// Every transfer takes exactly two clocks, setup and one access cycle
// pprot is accepted and has no effect
// irq carries one registered line per channel, bit i for channel i
`timescale 1ns/100ps
`default_nettype none

`include "apb4_tmr_settings.svh"

module apb4_tmr_top (
  input  logic                     apb4,
  input  logic                     arst_n,
  input  logic [`TMR_ADDR_W-1:0]   paddr,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [31:0]              pwdata,
  input  logic [3:0]               pstrb,
  input  logic [2:0]               pprot,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic [`TMR_CHANNELS-1:0] irq
);

  import apb4_tmr_pkg::*;

  apb4_req_t    bus_req;
  chn_req_arr_t chn_req;
  chn_rsp_arr_t chn_rsp;
  chn_idx_t     sel_idx;
  logic         unmapped;

  // Bus inputs gathered into one request, pprot has no field here
  assign bus_req = '{
    paddr:   paddr,
    pwrite:  pwrite,
    pwdata:  pwdata,
    pstrb:   pstrb,
    psel:    psel,
    penable: penable
  };

  apb4_tmr_decode apb4_tmr_decode_inst (
    .apb4     (apb4),
    .arst_n   (arst_n),
    .req      (bus_req),
    .chn_req  (chn_req),
    .unmapped (unmapped),
    .sel_idx  (sel_idx)
  );

  // One timer per channel window
  for (genvar i = 0; i < `TMR_CHANNELS; i++) begin : g_chn
    tmr_channel tmr_channel_inst (
      .apb4   (apb4),
      .arst_n (arst_n),
      .req    (chn_req[i]),
      .rsp    (chn_rsp[i]),
      .irq    (irq[i])
    );
  end

  apb4_tmr_rdmux apb4_tmr_rdmux_inst (
    .chn_rsp  (chn_rsp),
    .sel_idx  (sel_idx),
    .unmapped (unmapped),
    .penable  (penable),
    .psel     (psel),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr)
  );

endmodule

`default_nettype wire

/* apb4_tmr_assert.sv */
// Protocol and interrupt checks for the APB4 timer, bound into its top level
// Channel flag and interrupt enable are reached through the generate scope of the top
// Every failure also adds to fail_cnt, which the testbench reads for its summary
`timescale 1ns/100ps
`default_nettype none

`include "apb4_tmr_settings.svh"

module apb4_tmr_assert (
  input logic                     apb4,
  input logic                     arst_n,
  input logic                     psel,
  input logic                     penable,
  input logic                     pready,
  input logic                     pslverr,
  input logic [`TMR_CHANNELS-1:0] irq
);

  logic [`TMR_CHANNELS-1:0] flag_ie;

  // One counter per assertion so that each has a single writer
  int unsigned ready_fail = 0;
  int unsigned err_fail = 0;
  int unsigned setup_fail = 0;
  int unsigned irq_fail = 0;
  int unsigned fail_cnt;

  assign fail_cnt = ready_fail + err_fail + setup_fail + irq_fail;

  // Interrupt source of every channel, flag and enable together
  for (genvar i = 0; i < `TMR_CHANNELS; i++) begin : g_src
    assign flag_ie[i] = apb4_tmr_top.g_chn[i].tmr_channel_inst.flag_q &
                        apb4_tmr_top.g_chn[i].tmr_channel_inst.ie_q;
  end

  // No wait states, so pready marks the access cycle exactly
  a_ready_in_access: assert property (@(posedge apb4) disable iff (!arst_n)
    pready == (psel && penable))
  else begin
    $error("pready differs from the access cycle");
    ready_fail++;
  end

  // An error response only comes with pready
  a_err_with_ready: assert property (@(posedge apb4) disable iff (!arst_n)
    pslverr |-> pready)
  else begin
    $error("pslverr seen without pready");
    err_fail++;
  end

  // Every transfer completes in the clock right after its setup cycle
  a_ready_after_setup: assert property (@(posedge apb4) disable iff (!arst_n)
    (psel && !penable) |=> pready)
  else begin
    $error("transfer did not complete with pready in the access cycle");
    setup_fail++;
  end

  // irq is registered from flag and enable of the cycle before
  a_irq_source: assert property (@(posedge apb4) disable iff (!arst_n)
    (irq & ~$past(flag_ie)) == '0)
  else begin
    $error("irq high without flag and interrupt enable one cycle earlier");
    irq_fail++;
  end

endmodule

bind apb4_tmr_top apb4_tmr_assert apb4_tmr_assert_inst (
  .apb4    (apb4),
  .arst_n  (arst_n),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .irq     (irq)
);

`default_nettype wire

/* apb4_tmr_tb.sv */
// Testbench for the APB4 timer peripheral
// A blocking APB4 master drives on the rising edge and samples on the falling edge
// Register reads are compared with a model kept here from the register rules
// Protocol and irq timing are checked by the bound assertion module
// Assumes TMR_CHN_SHIFT is 4, so a register offset fills the low address nibble
`timescale 1ns/100ps
`default_nettype none

`include "apb4_tmr_settings.svh"

module apb4_tmr_tb;

  // Longest wait for pready in clocks, and for a compare match in polls
  localparam int READY_LIMIT = 16;
  localparam int POLL_LIMIT  = 64;

  logic                     apb4;
  logic                     arst_n;
  logic [`TMR_ADDR_W-1:0]   paddr;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [31:0]              pwdata;
  logic [3:0]               pstrb;
  logic [2:0]               pprot;
  logic [31:0]              prdata;
  logic                     pready;
  logic                     pslverr;
  logic [`TMR_CHANNELS-1:0] irq;

  integer seed = 82;
  int     data_errs = 0;
  int     wait_errs = 0;
  int     assert_errs = 0;
  int     cyc_cnt = 0;
  int     sample_cyc = 0;

  // Expected ctrl and cmp contents of every channel
  logic [31:0] ctrl_model [`TMR_CHANNELS];
  logic [31:0] cmp_model [`TMR_CHANNELS];

  apb4_tmr_top apb4_tmr_top_inst (
    .apb4    (apb4),
    .arst_n  (arst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .pprot   (pprot),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .irq     (irq)
  );

  initial apb4 = 1'b0;
  always #5 apb4 = ~apb4;

  // Clock count, used to time the compare match
  always @(posedge apb4) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  // Byte address of a register in a channel window
  function automatic logic [`TMR_ADDR_W-1:0] reg_addr(input int ch, input logic [3:0] ofs);
    logic [`TMR_ADDR_W-1:0] a;
    a = '0;
    a[`TMR_ADDR_W-1:`TMR_CHN_SHIFT] = ch[`TMR_ADDR_W-`TMR_CHN_SHIFT-1:0];
    a[`TMR_CHN_SHIFT-1:0] = ofs;
    return a;
  endfunction

  // New bytes replace old ones wherever the strobe is set
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got 0x%08h, expected 0x%08h", $time, name, got, exp);
      data_errs++;
    end
  endtask

  // Access cycle: wait for pready, sample the response, then release the bus
  task automatic finish_access(output logic [31:0] rdata, output logic err);
    int waited;
    waited = 0;
    @(negedge apb4);
    while (!pready && waited < READY_LIMIT) begin
      waited++;
      @(negedge apb4);
    end
    if (!pready) begin
      $display("Timeout at %0t: no pready for address 0x%03h", $time, paddr);
      wait_errs++;
    end
    rdata      = prdata;
    err        = pslverr;
    sample_cyc = cyc_cnt;
    @(posedge apb4);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [`TMR_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic err);
    logic [31:0] unused_rdata;
    @(posedge apb4);
    paddr   <= addr;
    pwrite  <= 1'b1;
    pwdata  <= data;
    pstrb   <= strb;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge apb4);
    penable <= 1'b1;
    finish_access(unused_rdata, err);
  endtask

  task automatic apb_read(input logic [`TMR_ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge apb4);
    paddr   <= addr;
    pwrite  <= 1'b0;
    pstrb   <= 4'h0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge apb4);
    penable <= 1'b1;
    finish_access(data, err);
  endtask

  task automatic write_ok(input int ch, input logic [3:0] ofs, input logic [31:0] data,
                          input logic [3:0] strb);
    logic err;
    apb_write(reg_addr(ch, ofs), data, strb, err);
    check_val($sformatf("ch%0d write pslverr", ch), 32'(err), 32'd0);
  endtask

  task automatic read_check(input int ch, input logic [3:0] ofs, input string reg_name,
                            input logic [31:0] exp);
    logic [31:0] data;
    logic        err;
    apb_read(reg_addr(ch, ofs), data, err);
    check_val($sformatf("ch%0d.%s", ch, reg_name), data, exp);
    check_val($sformatf("ch%0d.%s pslverr", ch, reg_name), 32'(err), 32'd0);
  endtask

  initial begin
    logic [31:0] rnd;
    logic [3:0]  strb;
    logic [31:0] rdata;
    logic        err;
    int          ch;
    int          n;
    int          idx;
    int          start_cyc;
    int          polls;
    logic        seen;

    arst_n  <= 1'b0;
    paddr   <= '0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    pwdata  <= '0;
    pstrb   <= 4'h0;
    pprot   <= 3'b000;
    for (int k = 0; k < `TMR_CHANNELS; k++) begin
      ctrl_model[k] = '0;
      cmp_model[k]  = '0;
    end
    repeat (3) @(posedge apb4);
    arst_n <= 1'b1;

    // Every register reads zero after reset
    for (int k = 0; k < `TMR_CHANNELS; k++) begin
      read_check(k, `TMR_OFS_CTRL, "ctrl", 32'd0);
      read_check(k, `TMR_OFS_CMP, "cmp", 32'd0);
      read_check(k, `TMR_OFS_CNT, "cnt", 32'd0);
      read_check(k, `TMR_OFS_STAT, "stat", 32'd0);
    end
    @(negedge apb4);
    check_val("irq", 32'(irq), 32'd0);

    // Random cmp writes under random strobes, all channels read back after each one
    for (int i = 0; i < 3 * `TMR_CHANNELS; i++) begin
      ch   = i % `TMR_CHANNELS;
      rnd  = $random(seed);
      strb = 4'($random(seed));
      write_ok(ch, `TMR_OFS_CMP, rnd, strb);
      cmp_model[ch] = merge_bytes(cmp_model[ch], rnd, strb);
      for (int k = 0; k < `TMR_CHANNELS; k++) begin
        read_check(k, `TMR_OFS_CMP, "cmp", cmp_model[k]);
      end
    end

    // Compare match on channel 1 with a small compare value
    n = 3 + int'($unsigned($random(seed)) % 6);
    write_ok(1, `TMR_OFS_CMP, 32'(n), 4'hF);
    cmp_model[1] = 32'(n);
    write_ok(1, `TMR_OFS_CTRL, 32'h1, 4'hF);
    ctrl_model[1] = 32'h1;
    // Counting starts at the edge that ends the enable write
    start_cyc = sample_cyc + 1;
    seen = 1'b0;
    polls = 0;
    while (!seen && polls < POLL_LIMIT) begin
      apb_read(reg_addr(1, `TMR_OFS_CNT), rdata, err);
      if (rdata > 32'(n)) begin
        $display("Mismatch at %0t: ch1.cnt got 0x%08h, expected at most 0x%08h",
                 $time, rdata, 32'(n));
        data_errs++;
      end
      apb_read(reg_addr(1, `TMR_OFS_STAT), rdata, err);
      seen = rdata[0];
      polls++;
    end
    if (!seen) begin
      $display("Timeout at %0t: the match flag of channel 1 was never set", $time);
      wait_errs++;
    end else if (sample_cyc - start_cyc < n + 1) begin
      $display("Mismatch at %0t: ch1 match delay got %0d cycles, expected at least %0d",
               $time, sample_cyc - start_cyc, n + 1);
      data_errs++;
    end

    // Stop the counter so that no new match refills the flag
    write_ok(1, `TMR_OFS_CTRL, 32'h0, 4'hF);
    write_ok(1, `TMR_OFS_STAT, 32'h0, 4'hF);
    read_check(1, `TMR_OFS_STAT, "stat", 32'h1);
    write_ok(1, `TMR_OFS_CTRL, 32'h2, 4'hF);
    ctrl_model[1] = 32'h2;
    // irq rises one clock after the interrupt enable
    @(posedge apb4);
    @(negedge apb4);
    check_val("irq", 32'(irq), 32'h2);
    write_ok(1, `TMR_OFS_STAT, 32'h1, 4'hF);
    read_check(1, `TMR_OFS_STAT, "stat", 32'h0);
    @(negedge apb4);
    check_val("irq", 32'(irq), 32'h0);

    // The counter refuses writes
    rnd = $random(seed);
    apb_write(reg_addr(0, `TMR_OFS_CNT), rnd, 4'hF, err);
    check_val("ch0.cnt write pslverr", 32'(err), 32'h1);
    read_check(0, `TMR_OFS_CNT, "cnt", 32'd0);

    // First window past the last channel, then the top of the address space
    for (int u = 0; u < 2; u++) begin
      idx = (u == 0) ? `TMR_CHANNELS : (1 << (`TMR_ADDR_W - `TMR_CHN_SHIFT)) - 1;
      rnd = $random(seed);
      apb_write(reg_addr(idx, `TMR_OFS_CMP), rnd, 4'hF, err);
      check_val("unmapped write pslverr", 32'(err), 32'h1);
      apb_read(reg_addr(idx, `TMR_OFS_CMP), rdata, err);
      check_val("unmapped prdata", rdata, 32'd0);
      check_val("unmapped read pslverr", 32'(err), 32'h1);
    end
    for (int k = 0; k < `TMR_CHANNELS; k++) begin
      read_check(k, `TMR_OFS_CTRL, "ctrl", ctrl_model[k]);
      read_check(k, `TMR_OFS_CMP, "cmp", cmp_model[k]);
    end

    assert_errs = int'(apb4_tmr_top_inst.apb4_tmr_assert_inst.fail_cnt);
    $display("Errors: %0d data, %0d timeout, %0d assertion", data_errs, wait_errs, assert_errs);
    if (data_errs == 0 && wait_errs == 0 && assert_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
apb4_tmr_pkg.sv
apb4_tmr_decode.sv
tmr_channel.sv
apb4_tmr_rdmux.sv
apb4_tmr_top.sv
apb4_tmr_assert.sv
apb4_tmr_tb.sv

/* run.sh */
#!/bin/sh
# Builds the APB4 timer testbench with Verilator and runs it
# The run fails on a build error, a nonzero simulator exit or a failure line in the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module apb4_tmr_tb \
  --Mdir "$BUILD_DIR" -o apb4_tmr_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# A high error limit keeps assertion failures from stopping the run early
"./$BUILD_DIR/apb4_tmr_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
  echo "Simulation log has no final status"
  exit 1
fi
exit 0
